/* center.sv */
// ================================================
// centre block top: scheduler, output buffer and
// PE-to-queue crossbar, instances and wiring only
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module center
    import center_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // row stream from the event queue
    input  logic                        row_valid_i,
    input  row_idx_t                    row_idx_i,
    input  row_delta_t                  row_delta_i,
    output logic                        row_ready_o,
    // PE lanes
    output logic        [`COL_NUM-1:0]  pe_valid_o,
    output delta_t      [`COL_NUM-1:0]  pe_delta_o,
    output vertex_idx_t [`COL_NUM-1:0]  pe_idx_o,
    input  logic        [`COL_NUM-1:0]  pe_ready_i,
    // producers
    input  logic        [`GEN_NUM-1:0]  pro_valid_i,
    input  delta_t      [`GEN_NUM-1:0]  pro_delta_i,
    input  vertex_idx_t [`GEN_NUM-1:0]  pro_idx_i,
    output logic        [`GEN_NUM-1:0]  pro_ready_o,
    // compute-unit bins
    output logic        [`BIN_NUM-1:0]  cu_valid_o,
    output delta_t      [`BIN_NUM-1:0]  cu_delta_o,
    output vertex_idx_t [`BIN_NUM-1:0]  cu_idx_o,
    input  logic        [`BIN_NUM-1:0]  cu_ready_i,
    // status and queue control
    input  logic        [`COL_NUM-1:0]  init_finish_i,
    input  logic        [`BIN_NUM-1:0]  bin_valid_i,
    input  logic        [`BIN_NUM-1:0]  cu_clean_i,
    output logic                        read_en_o,
    output logic        [`BIN_NUM-1:0]  bin_selected_o
);

    // accepted rows, counted against the budget
    logic row_fire;

    queue_scheduler u_queue_scheduler (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .init_finish_i  (init_finish_i),
        .bin_valid_i    (bin_valid_i),
        .cu_clean_i     (cu_clean_i),
        .row_fire_i     (row_fire),
        .read_en_o      (read_en_o),
        .bin_selected_o (bin_selected_o)
    );

    output_buffer u_output_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .read_en_i   (read_en_o),
        .row_valid_i (row_valid_i),
        .row_idx_i   (row_idx_i),
        .row_delta_i (row_delta_i),
        .row_ready_o (row_ready_o),
        .row_fire_o  (row_fire),
        .pe_valid_o  (pe_valid_o),
        .pe_delta_o  (pe_delta_o),
        .pe_idx_o    (pe_idx_o),
        .pe_ready_i  (pe_ready_i)
    );

    pe_to_queue_xbar u_pe_to_queue_xbar (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pro_valid_i (pro_valid_i),
        .pro_delta_i (pro_delta_i),
        .pro_idx_i   (pro_idx_i),
        .pro_ready_o (pro_ready_o),
        .cu_valid_o  (cu_valid_o),
        .cu_delta_o  (cu_delta_o),
        .cu_idx_o    (cu_idx_o),
        .cu_ready_i  (cu_ready_i)
    );

endmodule

/* center_macros.svh */
// ================================================
// shared sizing constants for the centre block
// include in any file that sizes ports or storage
// ================================================
`ifndef CENTER_MACROS_SVH
`define CENTER_MACROS_SVH

// event payload widths
`define DELTA_WIDTH      16
`define VERTEX_IDX_WIDTH 8
`define ROW_IDX_WIDTH    6

// lanes and bins
// one column per PE
`define COL_NUM          4
`define GEN_NUM          4
`define BIN_NUM          4
// bin number taken from vertex index bits upward from here
`define BIN_IDX_LSB      0

// buffering and drain limits
`define ROW_FIFO_DEPTH   4
`define BIN_FIFO_DEPTH   2
`define ROW_BUDGET       8

`endif

/* center_pkg.sv */
// ================================================
// event, row and index types for the centre block
// import with a wildcard in the module header
// ================================================
`include "center_macros.svh"

package center_pkg;

    typedef logic [`DELTA_WIDTH-1:0]      delta_t;
    typedef logic [`VERTEX_IDX_WIDTH-1:0] vertex_idx_t;
    typedef logic [`ROW_IDX_WIDTH-1:0]    row_idx_t;
    typedef logic [$clog2(`BIN_NUM)-1:0]  bin_idx_t;

    // one event as produced by a PE
    typedef struct packed {
        delta_t      delta;
        vertex_idx_t idx;
    } event_t;

    // all column deltas of one row, column 0 in the low bits
    typedef delta_t [`COL_NUM-1:0] row_delta_t;

    typedef struct packed {
        row_idx_t   idx;
        row_delta_t delta;
    } row_t;

endpackage

/* center_props.sv */
// ================================================
// concurrent checks on the centre block handshakes
// bound into every center instance from this file
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module center_props
    import center_pkg::*;
(
    input logic                        clk_i,
    input logic                        rst_n_i,
    input logic        [`COL_NUM-1:0]  init_finish_i,
    input logic                        read_en_o,
    input logic        [`BIN_NUM-1:0]  bin_selected_o,
    input logic        [`COL_NUM-1:0]  pe_valid_o,
    input delta_t      [`COL_NUM-1:0]  pe_delta_o,
    input vertex_idx_t [`COL_NUM-1:0]  pe_idx_o,
    input logic        [`COL_NUM-1:0]  pe_ready_i
);

    // sticky, set once every PE has finished its initial phase
    logic init_seen_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            init_seen_q <= 1'b0;
        end else if (&init_finish_i) begin
            init_seen_q <= 1'b1;
        end
    end

    // one bin only while draining
    a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_en_o |-> $onehot(bin_selected_o))
        else $error("bin_selected_o not one-hot while read_en_o is high");

    // no drain before the initial phase is over
    a_init_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !init_seen_q |-> !read_en_o)
        else $error("read_en_o high before all init_finish_i were seen");

    // a waiting lane holds valid and payload
    for (genvar i = 0; i < `COL_NUM; i++) begin : g_lane
        a_lane_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            pe_valid_o[i] && !pe_ready_i[i] |=>
                pe_valid_o[i] && $stable(pe_delta_o[i]) && $stable(pe_idx_o[i]))
            else $error("PE lane %0d dropped or changed before ready", i);
    end

endmodule

bind center center_props u_center_props (.*);

/* event_fifo.sv */
// ================================================
// small synchronous FIFO with valid/ready on both sides
// payload type set per instance, rows or bin events
// ================================================
`timescale 1ns/1ps

module event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_valid_i,
    input  payload_t push_data_i,
    output logic     push_ready_o,
    output logic     pop_valid_o,
    output payload_t pop_data_o,
    input  logic     pop_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t               mem [DEPTH];
    logic     [PTR_W-1:0]   wr_ptr_q;
    logic     [PTR_W-1:0]   rd_ptr_q;
    logic     [CNT_W-1:0]   count_q;
    logic                   do_push;
    logic                   do_pop;

    // full blocks the push, empty drops valid
    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem[rd_ptr_q];

    assign do_push = push_valid_i && push_ready_o;
    assign do_pop  = pop_valid_o && pop_ready_i;

    // storage, written at the tail
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers wrap at DEPTH
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* output_buffer.sv */
// ================================================
// buffers drained rows and issues non-zero deltas
// column i goes straight to PE i
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module output_buffer
    import center_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             read_en_i,
    input  logic                             row_valid_i,
    input  row_idx_t                         row_idx_i,
    input  row_delta_t                       row_delta_i,
    output logic                             row_ready_o,
    output logic                             row_fire_o,
    output logic        [`COL_NUM-1:0]       pe_valid_o,
    output delta_t      [`COL_NUM-1:0]       pe_delta_o,
    output vertex_idx_t [`COL_NUM-1:0]       pe_idx_o,
    input  logic        [`COL_NUM-1:0]       pe_ready_i
);

    row_t                in_row;
    row_t                head_row;
    logic                head_valid;
    logic                head_pop;
    logic                fifo_ready;
    logic                push_valid;
    logic [`COL_NUM-1:0] nz_mask;
    logic [`COL_NUM-1:0] sent_q;
    logic [`COL_NUM-1:0] lane_fire;

    assign in_row.idx   = row_idx_i;
    assign in_row.delta = row_delta_i;

    // rows only accepted during a drain
    assign push_valid  = row_valid_i && read_en_i;
    assign row_ready_o = read_en_i && fifo_ready;
    assign row_fire_o  = row_valid_i && row_ready_o;

    event_fifo #(
        .payload_t (row_t),
        .DEPTH     (`ROW_FIFO_DEPTH)
    ) u_row_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (push_valid),
        .push_data_i  (in_row),
        .push_ready_o (fifo_ready),
        .pop_valid_o  (head_valid),
        .pop_data_o   (head_row),
        .pop_ready_i  (head_pop)
    );

    // ================================================
    // per-lane issue from the head row
    // ================================================
    for (genvar i = 0; i < `COL_NUM; i++) begin : g_lane
        assign nz_mask[i]    = (head_row.delta[i] != '0);
        // zero columns are never issued
        assign pe_valid_o[i] = head_valid && nz_mask[i] && !sent_q[i];
        assign pe_delta_o[i] = head_row.delta[i];
        // vertex = row * columns + column
        assign pe_idx_o[i]   = vertex_idx_t'(head_row.idx) * vertex_idx_t'(`COL_NUM)
                             + vertex_idx_t'(i);
    end

    assign lane_fire = pe_valid_o & pe_ready_i;

    // pop once every non-zero lane has gone, all-zero rows pop at once
    assign head_pop = head_valid && (((sent_q | lane_fire) & nz_mask) == nz_mask);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sent_q <= '0;
        end else if (head_pop) begin
            sent_q <= '0;
        end else begin
            sent_q <= sent_q | lane_fire;
        end
    end

endmodule

/* pe_to_queue_xbar.sv */
// ================================================
// routes producer events to event-queue bins
// one round-robin arbiter and one FIFO per bin
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module pe_to_queue_xbar
    import center_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic        [`GEN_NUM-1:0]  pro_valid_i,
    input  delta_t      [`GEN_NUM-1:0]  pro_delta_i,
    input  vertex_idx_t [`GEN_NUM-1:0]  pro_idx_i,
    output logic        [`GEN_NUM-1:0]  pro_ready_o,
    output logic        [`BIN_NUM-1:0]  cu_valid_o,
    output delta_t      [`BIN_NUM-1:0]  cu_delta_o,
    output vertex_idx_t [`BIN_NUM-1:0]  cu_idx_o,
    input  logic        [`BIN_NUM-1:0]  cu_ready_i
);

    localparam int GEN_W = ($clog2(`GEN_NUM) > 0) ? $clog2(`GEN_NUM) : 1;
    localparam int BIN_W = $bits(bin_idx_t);
    localparam logic [`GEN_NUM-1:0] GEN_ONE = 1;

    bin_idx_t [`GEN_NUM-1:0]                pro_bin;
    logic     [`BIN_NUM-1:0][`GEN_NUM-1:0]  grant;

    // target bin from vertex index bits
    for (genvar g = 0; g < `GEN_NUM; g++) begin : g_gen
        assign pro_bin[g] = pro_idx_i[g][`BIN_IDX_LSB +: BIN_W];
    end

    // a producer targets one bin, so at most one grant each
    always_comb begin
        pro_ready_o = '0;
        for (int b = 0; b < `BIN_NUM; b++) begin
            pro_ready_o = pro_ready_o | grant[b];
        end
    end

    for (genvar b = 0; b < `BIN_NUM; b++) begin : g_bin
        logic [GEN_W-1:0]    rr_q;
        logic [GEN_W-1:0]    win_idx;
        logic                win_found;
        logic                fifo_ready;
        logic [`GEN_NUM-1:0] req;
        event_t              push_evt;
        event_t              pop_evt;

        // producers with a valid event for this bin
        for (genvar g = 0; g < `GEN_NUM; g++) begin : g_req
            assign req[g] = pro_valid_i[g] && (pro_bin[g] == bin_idx_t'(b));
        end

        // first requester for this bin at or after the pointer
        always_comb begin : arb
            int unsigned idx;
            win_found = 1'b0;
            win_idx   = rr_q;
            for (int k = 0; k < `GEN_NUM; k++) begin
                idx = (int'(rr_q) + k) % `GEN_NUM;
                if (!win_found && req[idx]) begin
                    win_found = 1'b1;
                    win_idx   = GEN_W'(idx);
                end
            end
        end

        // full bin grants nobody
        assign grant[b] = (win_found && fifo_ready) ? (GEN_ONE << win_idx) : '0;

        assign push_evt.delta = pro_delta_i[win_idx];
        assign push_evt.idx   = pro_idx_i[win_idx];

        // pointer moves past the winner
        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                rr_q <= '0;
            end else if (|grant[b]) begin
                rr_q <= GEN_W'((int'(win_idx) + 1) % `GEN_NUM);
            end
        end

        event_fifo #(
            .payload_t (event_t),
            .DEPTH     (`BIN_FIFO_DEPTH)
        ) u_bin_fifo (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .push_valid_i (win_found),
            .push_data_i  (push_evt),
            .push_ready_o (fifo_ready),
            .pop_valid_o  (cu_valid_o[b]),
            .pop_data_o   (pop_evt),
            .pop_ready_i  (cu_ready_i[b])
        );

        assign cu_delta_o[b] = pop_evt.delta;
        assign cu_idx_o[b]   = pop_evt.idx;
    end

endmodule

/* project.f */
+incdir+.
center_pkg.sv
event_fifo.sv
row_budget_counter.sv
queue_scheduler.sv
output_buffer.sv
pe_to_queue_xbar.sv
center.sv
center_props.sv
tb_center.sv

/* queue_scheduler.sv */
// ================================================
// picks event-queue bins round robin and drains them
// waits for the bin's compute unit to go clean after
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module queue_scheduler
    import center_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [`COL_NUM-1:0] init_finish_i,
    input  logic [`BIN_NUM-1:0] bin_valid_i,
    input  logic [`BIN_NUM-1:0] cu_clean_i,
    input  logic                row_fire_i,
    output logic                read_en_o,
    output logic [`BIN_NUM-1:0] bin_selected_o
);

    typedef enum logic [1:0] {
        IDLE,
        PICK,
        DRAIN,
        WAIT_CLEAN
    } state_t;

    localparam logic [`BIN_NUM-1:0] BIN_ONE = 1;

    state_t              state_q;
    state_t              state_d;
    bin_idx_t            last_q;
    logic [`BIN_NUM-1:0] sel_q;
    bin_idx_t            pick_idx;
    logic                pick_found;
    logic                budget_reached;
    logic                drain_done;

    // ================================================
    // round-robin search, starts after last served bin
    // ================================================
    always_comb begin : rr_search
        int unsigned idx;
        pick_found = 1'b0;
        pick_idx   = last_q;
        for (int k = 1; k <= `BIN_NUM; k++) begin
            idx = (int'(last_q) + k) % `BIN_NUM;
            if (!pick_found && bin_valid_i[idx]) begin
                pick_found = 1'b1;
                pick_idx   = bin_idx_t'(idx);
            end
        end
    end

    // drain stops on empty bin or spent budget
    assign drain_done = budget_reached || !(|(bin_valid_i & sel_q));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (&init_finish_i) state_d = PICK;
            PICK:       if (pick_found) state_d = DRAIN;
            DRAIN:      if (drain_done) state_d = WAIT_CLEAN;
            WAIT_CLEAN: if (|(cu_clean_i & sel_q)) state_d = PICK;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            // first search lands on bin 0
            last_q  <= bin_idx_t'(`BIN_NUM - 1);
            sel_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == PICK && pick_found) begin
                last_q <= pick_idx;
                sel_q  <= BIN_ONE << pick_idx;
            end
        end
    end

    // read enable drops in the same cycle the drain ends
    assign read_en_o      = (state_q == DRAIN) && !drain_done;
    // held through the clean wait so the CU knows its bin
    assign bin_selected_o = sel_q;

    // budget restarts on every pick
    row_budget_counter u_row_budget_counter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .clear_i          (state_q == PICK),
        .count_en_i       (row_fire_i),
        .budget_reached_o (budget_reached)
    );

endmodule

/* row_budget_counter.sv */
// ================================================
// counts rows taken in the current drain
// flags when the row budget is used up
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module row_budget_counter (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic clear_i,
    input  logic count_en_i,
    output logic budget_reached_o
);

    localparam int CNT_W = $clog2(`ROW_BUDGET + 1);

    logic [CNT_W-1:0] count_q;

    assign budget_reached_o = (count_q == CNT_W'(`ROW_BUDGET));

    // saturates at the budget
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (count_en_i && !budget_reached_o) begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

/* tb_center.sv */
// ================================================
// testbench for the centre block
// seeded random rows, producer events and status,
// checked against queue models kept here
// ================================================
`timescale 1ns/1ps
`include "center_macros.svh"

module tb_center
    import center_pkg::*;
();

    localparam int MAIN_CYCLES  = 4000;
    localparam int DRAIN_LIMIT  = 3000;

    logic                        clk_i;
    logic                        rst_n_i;
    logic                        row_valid_i;
    row_idx_t                    row_idx_i;
    row_delta_t                  row_delta_i;
    logic                        row_ready_o;
    logic        [`COL_NUM-1:0]  pe_valid_o;
    delta_t      [`COL_NUM-1:0]  pe_delta_o;
    vertex_idx_t [`COL_NUM-1:0]  pe_idx_o;
    logic        [`COL_NUM-1:0]  pe_ready_i;
    logic        [`GEN_NUM-1:0]  pro_valid_i;
    delta_t      [`GEN_NUM-1:0]  pro_delta_i;
    vertex_idx_t [`GEN_NUM-1:0]  pro_idx_i;
    logic        [`GEN_NUM-1:0]  pro_ready_o;
    logic        [`BIN_NUM-1:0]  cu_valid_o;
    delta_t      [`BIN_NUM-1:0]  cu_delta_o;
    vertex_idx_t [`BIN_NUM-1:0]  cu_idx_o;
    logic        [`BIN_NUM-1:0]  cu_ready_i;
    logic        [`COL_NUM-1:0]  init_finish_i;
    logic        [`BIN_NUM-1:0]  bin_valid_i;
    logic        [`BIN_NUM-1:0]  cu_clean_i;
    logic                        read_en_o;
    logic        [`BIN_NUM-1:0]  bin_selected_o;

    integer              seed;
    int                  error_count;
    int                  check_count;
    // model: expected events per PE lane and per bin
    event_t              pe_exp  [`COL_NUM][$];
    event_t              bin_exp [`BIN_NUM][$];
    // handshake results carried from posedge to negedge
    logic                row_fired;
    logic [`GEN_NUM-1:0] pro_fired;
    logic                stop_new;
    // drain interval tracking
    logic                init_all_seen;
    logic                read_en_prev;
    int                  rows_in_drain;
    logic [`BIN_NUM-1:0] served_sel;
    logic                wait_clean;
    logic                clean_seen;
    logic [`BIN_NUM-1:0] bins_seen;
    int                  waited;

    center DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ================================================
    // helpers
    // ================================================
    function automatic logic one_in(input int n);
        int r;
        r = $random(seed);
        return ((r & 32'h7fff_ffff) % n) == 0;
    endfunction

    // bin number from the index bits of a vertex
    function automatic bin_idx_t target_bin(input vertex_idx_t idx);
        return bin_idx_t'(idx >> `BIN_IDX_LSB);
    endfunction

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        error_count++;
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic plain_error(input string msg);
        error_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    function automatic logic work_pending();
        logic pending;
        pending = row_valid_i || (|pro_valid_i);
        for (int i = 0; i < `COL_NUM; i++) begin
            if (pe_exp[i].size() != 0) pending = 1'b1;
        end
        for (int b = 0; b < `BIN_NUM; b++) begin
            if (bin_exp[b].size() != 0) pending = 1'b1;
        end
        return pending;
    endfunction

    task automatic check_reset_outputs();
        check_count += 6;
        if (read_en_o !== 1'b0) value_error("read_en_o", read_en_o, 0);
        if (bin_selected_o !== '0) value_error("bin_selected_o", bin_selected_o, 0);
        if (pe_valid_o !== '0) value_error("pe_valid_o", pe_valid_o, 0);
        if (cu_valid_o !== '0) value_error("cu_valid_o", cu_valid_o, 0);
        if (pro_ready_o !== '0) value_error("pro_ready_o", pro_ready_o, 0);
        if (row_ready_o !== 1'b0) value_error("row_ready_o", row_ready_o, 0);
    endtask

    // ================================================
    // posedge sampling, model update and checks
    // ================================================
    task automatic track_drain();
        check_count++;
        if (!init_all_seen && read_en_o) begin
            plain_error("read_en_o went high before every init_finish_i was high");
        end
        if (&init_finish_i) init_all_seen = 1'b1;
        if (read_en_o && !read_en_prev) begin
            // start of a drain interval
            if (wait_clean && !clean_seen) begin
                plain_error("read_en_o rose before cu_clean_i of the served bin was high");
            end
            if ((bin_valid_i & bin_selected_o) == '0) begin
                plain_error("drain started on a bin whose bin_valid_i was low");
            end
            served_sel    = bin_selected_o;
            bins_seen     = bins_seen | bin_selected_o;
            wait_clean    = 1'b0;
            rows_in_drain = 0;
        end else if (read_en_o && bin_selected_o != served_sel) begin
            value_error("bin_selected_o", bin_selected_o, served_sel);
        end else if (!read_en_o && read_en_prev) begin
            // first low cycle still belongs to the drain
            wait_clean = 1'b1;
            clean_seen = 1'b0;
        end else if (!read_en_o && wait_clean && ((cu_clean_i & served_sel) != '0)) begin
            clean_seen = 1'b1;
        end
        read_en_prev = read_en_o;
    endtask

    task automatic sample_cycle();
        event_t exp_evt;
        event_t got_evt;
        int     hit;
        track_drain();
        // rows from the event queue
        if (row_valid_i && row_ready_o) begin
            check_count++;
            row_fired = 1'b1;
            if (!read_en_o) plain_error("row accepted while read_en_o was low");
            rows_in_drain++;
            if (rows_in_drain > `ROW_BUDGET) begin
                plain_error($sformatf("%0d rows accepted in one drain", rows_in_drain));
            end
            for (int i = 0; i < `COL_NUM; i++) begin
                if (row_delta_i[i] != '0) begin
                    exp_evt.delta = row_delta_i[i];
                    exp_evt.idx   = vertex_idx_t'(int'(row_idx_i) * `COL_NUM + i);
                    pe_exp[i].push_back(exp_evt);
                end
            end
        end
        // PE lanes, in row order
        for (int i = 0; i < `COL_NUM; i++) begin
            if (pe_valid_o[i] && pe_ready_i[i]) begin
                check_count++;
                if (pe_exp[i].size() == 0) begin
                    plain_error($sformatf("PE lane %0d issued an event nobody expected", i));
                end else begin
                    exp_evt = pe_exp[i].pop_front();
                    if (pe_delta_o[i] != exp_evt.delta) begin
                        value_error($sformatf("pe_delta_o[%0d]", i), pe_delta_o[i],
                                    exp_evt.delta);
                    end
                    if (pe_idx_o[i] != exp_evt.idx) begin
                        value_error($sformatf("pe_idx_o[%0d]", i), pe_idx_o[i], exp_evt.idx);
                    end
                end
            end
        end
        // producer events go to the bin of their index
        for (int g = 0; g < `GEN_NUM; g++) begin
            if (pro_valid_i[g] && pro_ready_o[g]) begin
                pro_fired[g]  = 1'b1;
                exp_evt.delta = pro_delta_i[g];
                exp_evt.idx   = pro_idx_i[g];
                bin_exp[target_bin(pro_idx_i[g])].push_back(exp_evt);
            end
        end
        // each bin output matched once and removed
        for (int b = 0; b < `BIN_NUM; b++) begin
            if (cu_valid_o[b] && cu_ready_i[b]) begin
                check_count++;
                got_evt.delta = cu_delta_o[b];
                got_evt.idx   = cu_idx_o[b];
                hit = -1;
                for (int k = 0; k < bin_exp[b].size(); k++) begin
                    if (hit < 0 && bin_exp[b][k] == got_evt) hit = k;
                end
                if (hit < 0) begin
                    plain_error($sformatf("bin %0d delivered unexpected event idx 0x%0h delta 0x%0h",
                                          b, cu_idx_o[b], cu_delta_o[b]));
                end else begin
                    bin_exp[b].delete(hit);
                end
            end
        end
    endtask

    // ================================================
    // negedge stimulus
    // ================================================
    task automatic drive_cycle();
        // payload held until the transfer
        if (!row_valid_i || row_fired) begin
            row_valid_i = !stop_new && !one_in(4);
            row_idx_i   = row_idx_t'($random(seed));
            for (int i = 0; i < `COL_NUM; i++) begin
                row_delta_i[i] = one_in(3) ? '0 : delta_t'($random(seed));
            end
        end
        row_fired = 1'b0;
        for (int g = 0; g < `GEN_NUM; g++) begin
            if (!pro_valid_i[g] || pro_fired[g]) begin
                pro_valid_i[g] = !stop_new && one_in(2);
                pro_delta_i[g] = delta_t'($random(seed));
                pro_idx_i[g]   = vertex_idx_t'($random(seed));
            end
        end
        pro_fired = '0;
        for (int i = 0; i < `COL_NUM; i++) begin
            pe_ready_i[i] = !one_in(3);
        end
        for (int b = 0; b < `BIN_NUM; b++) begin
            cu_ready_i[b] = !one_in(3);
            cu_clean_i[b] = one_in(4);
            if (one_in(6)) bin_valid_i[b] = ~bin_valid_i[b];
        end
    endtask

    task automatic run_cycle();
        @(posedge clk_i);
        sample_cycle();
        @(negedge clk_i);
        drive_cycle();
    endtask

    initial begin
        seed          = 54614;
        error_count   = 0;
        check_count   = 0;
        rst_n_i       = 1'b0;
        row_valid_i   = 1'b0;
        row_idx_i     = '0;
        row_delta_i   = '0;
        pe_ready_i    = '0;
        pro_valid_i   = '0;
        pro_delta_i   = '0;
        pro_idx_i     = '0;
        cu_ready_i    = '0;
        init_finish_i = '0;
        bin_valid_i   = '0;
        cu_clean_i    = '0;
        row_fired     = 1'b0;
        pro_fired     = '0;
        stop_new      = 1'b0;
        init_all_seen = 1'b0;
        read_en_prev  = 1'b0;
        rows_in_drain = 0;
        served_sel    = '0;
        wait_clean    = 1'b0;
        clean_seen    = 1'b0;
        bins_seen     = '0;

        // reset for 10 cycles
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(posedge clk_i);
        check_reset_outputs();

        // initial phase, one PE finishes every few cycles
        for (int c = 0; c < 24; c++) begin
            run_cycle();
            if (c % 6 == 5) init_finish_i[c / 6] = 1'b1;
        end

        for (int c = 0; c < MAIN_CYCLES; c++) begin
            run_cycle();
        end

        // stop new work and let everything in flight come out
        stop_new = 1'b1;
        waited   = 0;
        while (work_pending() && waited < DRAIN_LIMIT) begin
            run_cycle();
            waited++;
        end
        if (work_pending()) begin
            plain_error("timeout waiting for outstanding rows and events to drain");
        end
        check_count++;
        if (bins_seen != {`BIN_NUM{1'b1}}) begin
            plain_error($sformatf("not every bin was selected, seen mask 0x%0h", bins_seen));
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
